/* logic/console_pkg.sv */
package console_pkg;

  // --------------------------------------------------
  // Device select decoded from the top address nibble
  // --------------------------------------------------
  typedef enum logic [3:0] {
    dev_ram,
    dev_noise,
    dev_pad,
    dev_lcd,
    dev_audio,
    dev_none
  } dev_sel_t;

  // Address field that picks the device, patterns 000x RAM, 001x noise,
  // 011x pad, 110x LCD, 111x audio, anything else is unmapped
  localparam int SEL_HI = 31;
  localparam int SEL_LO = 28;

  // --------------------------------------------------
  // Noise source
  // --------------------------------------------------
  localparam logic [31:0] LFSR_SEED = 32'h1f2e_3d4c;  // Must not be zero
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

  // Buttons shifted in from the pad controller
  localparam int PAD_BITS = 8;

endpackage

/* logic/bus_controller.sv */
`timescale 1ns/1ps

module bus_controller
  import console_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                req,
  input  logic                we,
  input  logic [31:0]         addr,
  input  logic [31:0]         wdata,
  input  logic [3:0]          wstrb,
  input  logic                lcd_busy,
  input  logic                pad_busy,
  input  logic [31:0]         ram_rdata,
  input  logic [31:0]         noise_rdata,
  input  logic [PAD_BITS-1:0] pad_rdata,
  input  logic [7:0]          lcd_rdata,
  input  logic [31:0]         tone_rdata,
  output logic                ack,
  output logic [31:0]         rdata,
  output logic [SEL_LO-1:0]   offset,
  output logic [31:0]         dev_wdata,
  output logic [3:0]          dev_wstrb,
  output logic                ram_wr,
  output logic                ram_rd,
  output logic                noise_rd,
  output logic                pad_start,
  output logic                lcd_wr,
  output logic                tone_wr
);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_ISSUE = 2'd1;
  localparam logic [1:0] ST_WAIT  = 2'd2;
  localparam logic [1:0] ST_DONE  = 2'd3;

  logic [1:0]  state;
  logic        settle;      // High on the cycle the device samples its strobe
  logic        we_q;
  dev_sel_t    sel;
  dev_sel_t    sel_q;
  logic        dev_busy;
  logic [31:0] read_word;

  always_comb begin
    casez (addr[SEL_HI:SEL_LO])
      4'b000?: sel = dev_ram;
      4'b001?: sel = dev_noise;
      4'b011?: sel = dev_pad;
      4'b110?: sel = dev_lcd;
      4'b111?: sel = dev_audio;
      default: sel = dev_none;
    endcase
  end

  assign dev_busy = (sel_q == dev_pad && pad_busy) || (sel_q == dev_lcd && lcd_busy);

  always_comb begin
    case (sel_q)
      dev_ram:   read_word = ram_rdata;
      dev_noise: read_word = noise_rdata;
      dev_pad:   read_word = {{(32 - PAD_BITS){1'b0}}, pad_rdata};
      dev_lcd:   read_word = {24'b0, lcd_rdata};
      dev_audio: read_word = tone_rdata;
      default:   read_word = '0;  // Unmapped reads return zero
    endcase
  end

  // --------------------------------------------------
  // Handshake FSM
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      settle    <= 1'b0;
      ack       <= 1'b0;
      ram_wr    <= 1'b0;
      ram_rd    <= 1'b0;
      noise_rd  <= 1'b0;
      pad_start <= 1'b0;
      lcd_wr    <= 1'b0;
      tone_wr   <= 1'b0;
    end else begin
      ram_wr    <= 1'b0;  // Strobes last one cycle
      ram_rd    <= 1'b0;
      noise_rd  <= 1'b0;
      pad_start <= 1'b0;
      lcd_wr    <= 1'b0;
      tone_wr   <= 1'b0;
      case (state)
        ST_IDLE: if (req) state <= ST_ISSUE;
        ST_ISSUE: begin
          if (!dev_busy) begin  // Hold here while a scan or LCD write runs
            ram_wr    <= we_q && sel_q == dev_ram;
            ram_rd    <= !we_q && sel_q == dev_ram;
            noise_rd  <= !we_q && sel_q == dev_noise;
            pad_start <= we_q && sel_q == dev_pad;
            lcd_wr    <= we_q && sel_q == dev_lcd;
            tone_wr   <= we_q && sel_q == dev_audio;
            settle    <= 1'b1;
            state     <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (settle) begin
            settle <= 1'b0;
          end else if (!(we_q && sel_q == dev_lcd && lcd_busy)) begin
            ack   <= 1'b1;
            state <= ST_DONE;
          end
        end
        default: begin
          if (!req) begin
            ack   <= 1'b0;
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // Request and read word registers
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req) begin
      sel_q     <= sel;
      we_q      <= we;
      offset    <= addr[SEL_LO-1:0];
      dev_wdata <= wdata;
      dev_wstrb <= wstrb;
    end
    if (state == ST_WAIT && !settle) rdata <= read_word;
  end

  ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(ack) |-> $past(req));

  one_strobe: assert property (@(posedge clk) disable iff (reset)
    $onehot0({ram_wr, ram_rd, noise_rd, pad_start, lcd_wr, tone_wr}));

endmodule

/* logic/word_ram.sv */
`timescale 1ns/1ps

module word_ram
  import console_pkg::*;
#(
  parameter int RAM_ADDR_BITS = 10
) (
  input  logic              clk,
  input  logic [SEL_LO-1:0] offset,
  input  logic [31:0]       wdata,
  input  logic [3:0]        wstrb,
  input  logic              wr,
  input  logic              rd,
  output logic [31:0]       rdata
);

  logic [31:0]              mem [2**RAM_ADDR_BITS];
  logic [RAM_ADDR_BITS-1:0] word_addr;

  assign word_addr = offset[RAM_ADDR_BITS+1:2];  // Offset is a byte address

  always_ff @(posedge clk) begin
    if (wr) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (wstrb[lane]) mem[word_addr][lane*8 +: 8] <= wdata[lane*8 +: 8];
      end
    end
    if (rd) rdata <= mem[word_addr];
  end

endmodule

/* logic/noise_source.sv */
`timescale 1ns/1ps

module noise_source
  import console_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        rd,
  output logic [31:0] rdata
);

  logic [31:0] state;
  logic [31:0] next_state;

  // Galois form, shift right and fold the taps in when a one drops out
  assign next_state = state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);

  // The controller latches after the step, so a read returns the new state
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= LFSR_SEED;
    end else if (rd) begin
      state <= next_state;
    end
  end

  assign rdata = state;

  never_zero: assert property (@(posedge clk) disable iff (reset) state != '0);

endmodule

/* logic/lcd_writer.sv */
`timescale 1ns/1ps

module lcd_writer #(
  parameter int LCD_PULSE = 4
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       wr,
  input  logic       rs_sel,
  input  logic [7:0] wdata,
  output logic       busy,
  output logic [7:0] rdata,
  output logic [7:0] lcd_data,
  output logic       lcd_rs,
  output logic       lcd_enable
);

  localparam int CNT_BITS = $clog2(2 * LCD_PULSE) + 1;

  logic [CNT_BITS-1:0] count;

  // --------------------------------------------------
  // Enable pulse, then the same again as hold time
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      busy       <= 1'b0;
      lcd_enable <= 1'b0;
      count      <= '0;
    end else if (busy) begin
      count <= count + 1'b1;
      if (count == CNT_BITS'(LCD_PULSE - 1)) lcd_enable <= 1'b0;
      if (count == CNT_BITS'(2 * LCD_PULSE - 1)) busy <= 1'b0;
    end else if (wr) begin
      busy       <= 1'b1;
      lcd_enable <= 1'b1;
      count      <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr && !busy) begin
      lcd_data <= wdata;
      lcd_rs   <= rs_sel;  // Odd address selects the data register
    end
  end

  assign rdata = lcd_data;

  enable_in_busy: assert property (@(posedge clk) disable iff (reset)
    lcd_enable |-> busy);

endmodule

/* logic/tone_generator.sv */
`timescale 1ns/1ps

module tone_generator (
  input  logic        clk,
  input  logic        reset,
  input  logic        wr,
  input  logic [31:0] wdata,
  output logic [31:0] rdata,
  output logic        audio_out
);

  logic        tone_on;
  logic [15:0] half_period;
  logic [15:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      tone_on     <= 1'b0;
      half_period <= '0;
      count       <= '0;
      audio_out   <= 1'b0;
    end else if (wr) begin
      tone_on     <= wdata[31];
      half_period <= wdata[15:0];
      count       <= '0;
      audio_out   <= 1'b0;  // Each new setting starts from a low phase
    end else if (!tone_on || half_period == '0) begin
      count     <= '0;
      audio_out <= 1'b0;
    end else if (count == half_period - 16'd1) begin
      count     <= '0;
      audio_out <= ~audio_out;
    end else begin
      count <= count + 16'd1;
    end
  end

  assign rdata = {tone_on, 15'b0, half_period};

endmodule

/* logic/pad_reader.sv */
`timescale 1ns/1ps

module pad_reader
  import console_pkg::*;
#(
  parameter int PAD_HALF = 3
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  logic                pad_data,
  output logic                busy,
  output logic [PAD_BITS-1:0] rdata,
  output logic                pad_latch,
  output logic                pad_clock
);

  localparam int TIMER_BITS = $clog2(PAD_HALF + 1);
  localparam int BIT_BITS   = $clog2(PAD_BITS + 1);

  localparam logic [1:0] PH_IDLE  = 2'd0;
  localparam logic [1:0] PH_LATCH = 2'd1;
  localparam logic [1:0] PH_HIGH  = 2'd2;
  localparam logic [1:0] PH_LOW   = 2'd3;

  logic [1:0]            phase;
  logic [TIMER_BITS-1:0] timer;
  logic [BIT_BITS-1:0]   bit_count;
  logic [PAD_BITS-1:0]   shift;
  logic                  phase_end;

  assign phase_end = timer == TIMER_BITS'(PAD_HALF - 1);
  assign busy      = phase != PH_IDLE;

  always_ff @(posedge clk) begin
    if (reset) begin
      phase     <= PH_IDLE;
      timer     <= '0;
      bit_count <= '0;
      pad_latch <= 1'b0;
      pad_clock <= 1'b0;
    end else begin
      timer <= phase_end ? '0 : timer + 1'b1;
      case (phase)
        PH_IDLE: begin
          timer <= '0;
          if (start) begin
            pad_latch <= 1'b1;
            bit_count <= '0;
            phase     <= PH_LATCH;
          end
        end
        PH_HIGH: begin
          if (phase_end) begin
            pad_clock <= 1'b0;
            phase     <= PH_LOW;
          end
        end
        default: begin  // Latch or low phase, both lead into a clock pulse
          if (phase_end) begin
            pad_latch <= 1'b0;
            if (bit_count == BIT_BITS'(PAD_BITS)) begin
              phase <= PH_IDLE;
            end else begin
              pad_clock <= 1'b1;
              bit_count <= bit_count + 1'b1;
              phase     <= PH_HIGH;
            end
          end
        end
      endcase
    end
  end

  // First bit ends up in bit zero after the last shift
  always_ff @(posedge clk) begin
    if (phase != PH_IDLE && phase != PH_HIGH && phase_end) begin
      if (bit_count == BIT_BITS'(PAD_BITS)) rdata <= shift;
      else shift <= {pad_data, shift[PAD_BITS-1:1]};
    end
  end

endmodule

/* logic/console_io.sv */
`timescale 1ns/1ps

module console_io
  import console_pkg::*;
#(
  parameter int RAM_ADDR_BITS = 10,
  parameter int LCD_PULSE     = 4,
  parameter int PAD_HALF      = 3
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        req,
  input  logic        we,
  input  logic [31:0] addr,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        pad_data,
  output logic        ack,
  output logic [31:0] rdata,
  output logic [7:0]  lcd_data,
  output logic        lcd_rs,
  output logic        lcd_enable,
  output logic        audio_out,
  output logic        pad_latch,
  output logic        pad_clock
);

  logic [SEL_LO-1:0]   offset;
  logic [31:0]         dev_wdata;
  logic [3:0]          dev_wstrb;
  logic                ram_wr, ram_rd, noise_rd, pad_start, lcd_wr, tone_wr;
  logic                lcd_busy, pad_busy;
  logic [31:0]         ram_rdata, noise_rdata, tone_rdata;
  logic [PAD_BITS-1:0] pad_rdata;
  logic [7:0]          lcd_rdata;

  bus_controller bus_controller_inst (
    .clk(clk), .reset(reset),
    .req(req), .we(we), .addr(addr), .wdata(wdata), .wstrb(wstrb),
    .lcd_busy(lcd_busy), .pad_busy(pad_busy),
    .ram_rdata(ram_rdata), .noise_rdata(noise_rdata), .pad_rdata(pad_rdata),
    .lcd_rdata(lcd_rdata), .tone_rdata(tone_rdata),
    .ack(ack), .rdata(rdata),
    .offset(offset), .dev_wdata(dev_wdata), .dev_wstrb(dev_wstrb),
    .ram_wr(ram_wr), .ram_rd(ram_rd), .noise_rd(noise_rd),
    .pad_start(pad_start), .lcd_wr(lcd_wr), .tone_wr(tone_wr)
  );

  word_ram #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) word_ram_inst (
    .clk(clk), .offset(offset), .wdata(dev_wdata), .wstrb(dev_wstrb),
    .wr(ram_wr), .rd(ram_rd), .rdata(ram_rdata)
  );

  noise_source noise_source_inst (
    .clk(clk), .reset(reset), .rd(noise_rd), .rdata(noise_rdata)
  );

  lcd_writer #(.LCD_PULSE(LCD_PULSE)) lcd_writer_inst (
    .clk(clk), .reset(reset),
    .wr(lcd_wr), .rs_sel(offset[0]), .wdata(dev_wdata[7:0]),
    .busy(lcd_busy), .rdata(lcd_rdata),
    .lcd_data(lcd_data), .lcd_rs(lcd_rs), .lcd_enable(lcd_enable)
  );

  tone_generator tone_generator_inst (
    .clk(clk), .reset(reset), .wr(tone_wr), .wdata(dev_wdata),
    .rdata(tone_rdata), .audio_out(audio_out)
  );

  pad_reader #(.PAD_HALF(PAD_HALF)) pad_reader_inst (
    .clk(clk), .reset(reset), .start(pad_start), .pad_data(pad_data),
    .busy(pad_busy), .rdata(pad_rdata),
    .pad_latch(pad_latch), .pad_clock(pad_clock)
  );

endmodule

/* verif/console_io_tests.svh */
logic [31:0] ram_model [1024];
logic [9:0]  ram_offsets [20];

task automatic test_ram();
  logic [31:0] value;
  logic [31:0] got;
  for (int i = 0; i < 20; i++) begin
    value          = lcg_next();
    ram_offsets[i] = value[9:0];
    value          = lcg_next();
    ram_model[ram_offsets[i]] = value;
    bus_write(dev_addr(dev_ram, {16'h0, ram_offsets[i], 2'b00}), value, 4'hf);
  end
  // Replace lane 2 of one word only
  value = lcg_next();
  ram_model[ram_offsets[7]][23:16] = value[23:16];
  bus_write(dev_addr(dev_ram, {16'h0, ram_offsets[7], 2'b00}), value, 4'b0100);
  for (int i = 0; i < 20; i++) begin
    bus_read(dev_addr(dev_ram, {16'h0, ram_offsets[i], 2'b00}), got);
    if (got !== ram_model[ram_offsets[i]]) begin
      $display("ERR rdata ram word %h expected %h got %h",
               ram_offsets[i], ram_model[ram_offsets[i]], got);
      errors++;
    end
    if (i == 0 && last_latency != 3) begin
      $display("RAM read ack came %0d cycles after req instead of 3", last_latency);
      errors++;
    end
  end
endtask

task automatic test_noise();
  logic [31:0] expected;
  logic [31:0] got;
  expected = LFSR_SEED;
  repeat (6) begin
    expected = expected[0] ? ((expected >> 1) ^ LFSR_TAPS) : (expected >> 1);
    bus_read(dev_addr(dev_noise, 28'h0), got);
    if (got !== expected) begin
      $display("ERR rdata noise expected %h got %h", expected, got);
      errors++;
    end
  end
endtask

task automatic lcd_write_checked(input logic rs, input logic [7:0] value);
  int width;
  int fall_cycle;
  width      = 0;
  fall_cycle = 0;
  fork
    bus_write(dev_addr(dev_lcd, {27'h0, rs}), {24'h0, value}, 4'hf);
    begin
      @(posedge lcd_enable);
      @(negedge clk);
      if (lcd_data !== value) begin
        $display("ERR lcd_data expected %h got %h", value, lcd_data);
        errors++;
      end
      if (lcd_rs !== rs) begin
        $display("ERR lcd_rs expected %h got %h", rs, lcd_rs);
        errors++;
      end
      while (lcd_enable) begin
        width++;
        @(negedge clk);
      end
      fall_cycle = cycle;
    end
  join
  if (width != LCD_PULSE) begin
    $display("LCD enable stayed high %0d cycles instead of %0d", width, LCD_PULSE);
    errors++;
  end
  if (ack_cycle <= fall_cycle) begin
    $display("LCD write was acked before the enable pulse ended");
    errors++;
  end
endtask

task automatic test_lcd();
  logic [31:0] got;
  lcd_write_checked(1'b0, 8'h38);  // Command register
  lcd_write_checked(1'b1, 8'h41);
  bus_read(dev_addr(dev_lcd, 28'h0), got);
  if (got !== 32'h41) begin
    $display("ERR rdata lcd expected %h got %h", 32'h41, got);
    errors++;
  end
  if (last_latency != 3) begin
    $display("LCD read ack came %0d cycles after req instead of 3", last_latency);
    errors++;
  end
endtask

task automatic toggle_gap(output int gap);
  logic level;
  level = audio_out;
  gap   = 0;
  do begin
    @(negedge clk);
    gap++;
  end while (audio_out == level && gap < 100);
endtask

task automatic test_tone();
  logic [31:0] got;
  int          gap;
  int          high_cycles;
  bus_write(dev_addr(dev_audio, 28'h0), 32'h8000_0005, 4'hf);
  toggle_gap(gap);  // Lines up with the first toggle
  repeat (3) begin
    toggle_gap(gap);
    if (gap != 5) begin
      $display("Audio toggled after %0d cycles instead of 5", gap);
      errors++;
    end
  end
  bus_read(dev_addr(dev_audio, 28'h0), got);
  if (got !== 32'h8000_0005) begin
    $display("ERR rdata tone expected %h got %h", 32'h8000_0005, got);
    errors++;
  end
  bus_write(dev_addr(dev_audio, 28'h0), 32'h0000_0005, 4'hf);
  high_cycles = 0;
  repeat (30) begin
    @(negedge clk);
    if (audio_out !== 1'b0) high_cycles++;
  end
  if (high_cycles != 0) begin
    $display("Audio was high for %0d cycles with the tone disabled", high_cycles);
    errors++;
  end
endtask

task automatic test_pad();
  logic [31:0] value;
  logic [31:0] got;
  value      = lcg_next();
  buttons    = value[7:0];
  pad_pulses = 0;
  bus_write(dev_addr(dev_pad, 28'h0), 32'h0, 4'hf);
  bus_read(dev_addr(dev_pad, 28'h0), got);  // Held off until the scan ends
  if (got !== {24'h0, buttons}) begin
    $display("ERR rdata pad expected %h got %h", {24'h0, buttons}, got);
    errors++;
  end
  if (pad_pulses != 8) begin
    $display("Saw %0d pad clock pulses instead of 8", pad_pulses);
    errors++;
  end
endtask

task automatic test_unmapped();
  logic [31:0] got;
  bus_write(dev_addr(dev_none, {16'h0, ram_offsets[0], 2'b00}), 32'hdead_beef, 4'hf);
  if (last_latency != 3) begin
    $display("Unmapped write ack came %0d cycles after req instead of 3", last_latency);
    errors++;
  end
  bus_read(dev_addr(dev_none, {16'h0, ram_offsets[0], 2'b00}), got);
  if (got !== 32'h0) begin
    $display("ERR rdata unmapped expected %h got %h", 32'h0, got);
    errors++;
  end
  if (last_latency != 3) begin
    $display("Unmapped read ack came %0d cycles after req instead of 3", last_latency);
    errors++;
  end
  bus_read(dev_addr(dev_ram, {16'h0, ram_offsets[0], 2'b00}), got);
  if (got !== ram_model[ram_offsets[0]]) begin
    $display("ERR rdata ram after unmapped write expected %h got %h",
             ram_model[ram_offsets[0]], got);
    errors++;
  end
endtask

/* verif/console_io_tb.sv */
`timescale 1ns/1ps

module console_io_tb
  import console_pkg::*;
();

  localparam int RAM_ADDR_BITS = 10;
  localparam int LCD_PULSE     = 4;
  localparam int PAD_HALF      = 3;
  localparam int ACK_LIMIT     = 200;
  localparam int MAX_CYCLES    = 5000;

  logic        clk;
  logic        reset;
  logic        req;
  logic        we;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        pad_data;
  logic        ack;
  logic [31:0] rdata;
  logic [7:0]  lcd_data;
  logic        lcd_rs;
  logic        lcd_enable;
  logic        audio_out;
  logic        pad_latch;
  logic        pad_clock;

  int          errors = 0;
  int          cycle = 0;
  int          last_latency;  // Edges from the one that saw req up to the one that raised ack
  int          ack_cycle;
  logic [31:0] lcg_state = 32'd89913;

  console_io #(
    .RAM_ADDR_BITS(RAM_ADDR_BITS), .LCD_PULSE(LCD_PULSE), .PAD_HALF(PAD_HALF)
  ) console_io_inst (
    .clk(clk), .reset(reset), .req(req), .we(we), .addr(addr), .wdata(wdata),
    .wstrb(wstrb), .pad_data(pad_data), .ack(ack), .rdata(rdata),
    .lcd_data(lcd_data), .lcd_rs(lcd_rs), .lcd_enable(lcd_enable),
    .audio_out(audio_out), .pad_latch(pad_latch), .pad_clock(pad_clock)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle++;
    if (cycle >= MAX_CYCLES) begin
      $display("Run stopped at the cycle limit of %0d, %0d errors so far", cycle, errors);
      $display("Errors found");
      $finish;
    end
  end

  // --------------------------------------------------
  // Pad controller model
  // --------------------------------------------------
  logic [7:0] buttons = 8'h00;
  int         pad_index = 0;
  int         pad_pulses = 0;

  always @(posedge pad_latch or negedge pad_clock) begin
    #1;
    if (pad_latch) begin  // Latch pulse reloads the shift register
      pad_index = 0;
    end else begin
      pad_index++;
    end
    pad_data = (pad_index < PAD_BITS) ? buttons[pad_index] : 1'b0;
  end

  always @(posedge pad_clock) pad_pulses++;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Builds a bus address from a device and the low 28 bits
  function automatic logic [31:0] dev_addr(dev_sel_t dev, logic [27:0] low);
    logic [3:0] top;
    case (dev)
      dev_ram:   top = 4'h0;
      dev_noise: top = 4'h2;
      dev_pad:   top = 4'h6;
      dev_lcd:   top = 4'hc;
      dev_audio: top = 4'he;
      default:   top = 4'h4;  // Pattern 0100 is unmapped
    endcase
    return {top, low};
  endfunction

  // --------------------------------------------------
  // Four-phase bus access
  // --------------------------------------------------
  task automatic bus_cycle(input logic is_write, input logic [31:0] a, input logic [31:0] d,
                           input logic [3:0] s, output logic [31:0] rd);
    int n;
    rd = '0;
    @(posedge clk);
    #1;
    addr  = a;
    we    = is_write;
    wdata = d;
    wstrb = s;
    req   = 1'b1;
    @(posedge clk);  // This edge sees req high
    #1;
    n = 0;
    while (!ack && n < ACK_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    last_latency = n;
    ack_cycle    = cycle;
    rd           = rdata;
    req          = 1'b0;
    if (!ack) begin
      $display("Access to address %h got no ack within %0d cycles", a, ACK_LIMIT);
      errors++;
    end
    n = 0;
    while (ack && n < ACK_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (ack) begin
      $display("Ack stayed high after req fell at address %h", a);
      errors++;
    end
  endtask

  task automatic bus_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
    logic [31:0] unused;
    bus_cycle(1'b1, a, d, s, unused);
  endtask

  task automatic bus_read(input logic [31:0] a, output logic [31:0] d);
    bus_cycle(1'b0, a, 32'h0, 4'hf, d);
  endtask

  `include "console_io_tests.svh"

  initial begin
    reset    = 1'b1;
    req      = 1'b0;
    we       = 1'b0;
    addr     = '0;
    wdata    = '0;
    wstrb    = '0;
    pad_data = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    test_ram();
    test_noise();
    test_lcd();
    test_tone();
    test_pad();
    test_unmapped();
    $display("Run complete after %0d cycles with %0d errors", cycle, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+verif
logic/console_pkg.sv
logic/bus_controller.sv
logic/word_ram.sv
logic/noise_source.sv
logic/lcd_writer.sv
logic/tone_generator.sv
logic/pad_reader.sv
logic/console_io.sv
verif/console_io_tb.sv

/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module console_io_tb -o console_io_sim \
  && ./obj_dir/console_io_sim > sim.log 2>&1 \
  || echo "Errors found" >> sim.log
cat sim.log
grep -q "Errors found" sim.log && exit 1
exit 0
